/* common/cdi_host_pkg.sv */
package cdi_host_pkg;

    // ======================================================================
    // Widths with a meaning
    // ======================================================================

    typedef logic [24:0] sdram_addr_t;
    typedef logic [15:0] word16_t;
    typedef logic [7:0]  byte_t;
    typedef logic [24:0] host_addr_t;

    // Byte address into the 8 kB NvRAM or the slave WORM
    typedef logic [12:0] mem13_addr_t;

    // ======================================================================
    // Bundles
    // ======================================================================

    typedef struct packed {
        sdram_addr_t addr;
        word16_t     din;
        logic        rd;
        logic        wr;
        logic        word;
        logic        refresh;
        logic        burst;
    } sdram_req_t;

    // Host loader download port
    typedef struct packed {
        logic        download;
        logic        wr;
        host_addr_t  addr;
        word16_t     dout;
        logic [15:0] index;
    } host_dl_t;

    typedef struct packed {
        mem13_addr_t adr;
        byte_t       data;
        logic        wr;
    } worm_wr_t;

    // SD card sector buffer as seen from the host side
    typedef struct packed {
        logic [7:0] addr;
        logic       wr;
        word16_t    dout;
    } sd_buff_t;

    // ======================================================================
    // State machines
    // ======================================================================

    typedef enum logic [1:0] {
        ROM_DOWNLOAD = 2'd0,
        REFRESH      = 2'd1,
        IDLE         = 2'd2
    } sdram_owner_e;

    typedef enum logic [3:0] {
        NVRAM_IDLE         = 4'd0,
        NVRAM_WAIT_FOR_ACK = 4'd1,
        NVRAM_BACKUP0      = 4'd2,
        NVRAM_BACKUP1      = 4'd3,
        NVRAM_BACKUP2      = 4'd4,
        NVRAM_BACKUP3      = 4'd5,
        NVRAM_RESTORE0     = 4'd6,
        NVRAM_RESTORE1     = 4'd7,
        NVRAM_RESTORE2     = 4'd8
    } nvram_state_e;

    // Index bit 6 set means slave WORM, clear means main boot ROM
    localparam int SLAVE_SELECT_BIT = 6;

    localparam logic [2:0] ROM_REGION_PREFIX = 3'b001;

endpackage

/* sdram_prep/sdram_prep_arbiter.sv */
`timescale 1ns/1ps

module sdram_prep_arbiter (
    input  logic                     clk_sys,
    input  logic                     cditop_reset,
    input  cdi_host_pkg::host_dl_t   dl,
    input  cdi_host_pkg::sdram_req_t core_req,
    input  logic                     sdram_busy,
    output cdi_host_pkg::sdram_req_t mem_req,
    output logic                     dl_overflow
);
    import cdi_host_pkg::*;

    sdram_owner_e owner;
    sdram_owner_e owner_q;
    sdram_owner_e owner_next;
    sdram_req_t   prep_req;
    logic         wr_latch;
    logic         busy_q;
    logic         reset_q = 1'b0;
    logic         reset_rise;
    logic         main_rom_wr;

    assign main_rom_wr = dl.wr && !dl.index[SLAVE_SELECT_BIT];

    // A new reset period starts a fresh download
    assign reset_rise = cditop_reset && !reset_q;

    // ======================================================================
    // Owner selection
    // ======================================================================

    always_comb begin
        owner_next = IDLE;
        if (cditop_reset) begin
            // Pending download word beats refresh
            owner_next = wr_latch ? ROM_DOWNLOAD : REFRESH;
        end

        // Keep the owner of the running access
        owner = sdram_busy ? owner_q : owner_next;
    end

    always_comb begin
        prep_req = '0;
        prep_req.word = 1'b1;

        case (owner)
            ROM_DOWNLOAD: begin
                // Host sends little endian, the 68k side wants big endian
                prep_req.addr = {ROM_REGION_PREFIX, dl.addr[21:1], 1'b0};
                prep_req.din  = {dl.dout[7:0], dl.dout[15:8]};
                // Skip the first idle cycle after a finished access
                prep_req.wr   = !busy_q;
            end
            REFRESH: begin
                prep_req.rd      = 1'b1;
                prep_req.refresh = 1'b1;
            end
            default: begin
                prep_req.rd = 1'b0;
            end
        endcase

        if (sdram_busy) begin
            prep_req.rd = 1'b0;
            prep_req.wr = 1'b0;
        end
    end

    // Core only sees the memory outside reset
    assign mem_req = cditop_reset ? prep_req : core_req;

    // ======================================================================
    // Download latch and overflow
    // ======================================================================

    always_ff @(posedge clk_sys) begin
        reset_q <= cditop_reset;
        busy_q  <= sdram_busy;

        if (reset_rise) begin
            owner_q     <= IDLE;
            wr_latch    <= 1'b0;
            dl_overflow <= 1'b0;
        end else begin
            owner_q <= owner;

            // Host word arrived before the previous one was stored
            if (wr_latch && dl.wr) begin
                dl_overflow <= 1'b1;
            end

            // Write finished once busy drops
            if (owner_q == ROM_DOWNLOAD && busy_q && !sdram_busy) begin
                wr_latch <= 1'b0;
            end
        end

        if (cditop_reset && main_rom_wr) begin
            wr_latch <= 1'b1;
        end
    end

endmodule

/* logic/worm_loader.sv */
`timescale 1ns/1ps

module worm_loader (
    input  logic                   clk_sys,
    input  cdi_host_pkg::host_dl_t dl,
    output cdi_host_pkg::worm_wr_t worm
);
    import cdi_host_pkg::*;

    logic  slave_wr;
    logic  slave_wr_q;
    byte_t upper_byte;

    assign slave_wr = dl.wr && dl.index[SLAVE_SELECT_BIT];

    // Two byte writes per host word
    always_ff @(posedge clk_sys) begin
        slave_wr_q <= slave_wr;
        worm.wr    <= slave_wr || slave_wr_q;

        if (slave_wr) begin
            // Lower byte goes out first
            worm.adr   <= dl.addr[12:0];
            worm.data  <= dl.dout[7:0];
            upper_byte <= dl.dout[15:8];
        end else begin
            // Then the upper byte at the odd address
            worm.data   <= upper_byte;
            worm.adr[0] <= 1'b1;
        end
    end

endmodule

/* nvram/nvram_backup_policy.sv */
`timescale 1ns/1ps

module nvram_backup_policy #(
    parameter int BOOT_IGNORE_CYCLES = 120_000_000
) (
    input  logic        clk_sys,
    input  logic        cditop_reset,
    input  logic        nvram_media_change,
    input  logic [63:0] img_size,
    input  logic        nvram_cpu_changed,
    input  logic        backup_start,
    output logic        img_mount,
    output logic        backup_pending
);

    localparam int CNT_W = (BOOT_IGNORE_CYCLES > 1) ? $clog2(BOOT_IGNORE_CYCLES + 1) : 1;

    logic [CNT_W-1:0] ignore_cnt;

    // Survives a console reset, only a media change updates it
    logic image_mounted = 1'b0;

    assign img_mount = nvram_media_change && (img_size != 64'd0);

    always_ff @(posedge clk_sys) begin
        if (nvram_media_change) begin
            image_mounted <= (img_size != 64'd0);
        end
    end

    // ======================================================================
    // Pending backup flag
    // ======================================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            backup_pending <= 1'b0;
            ignore_cnt     <= CNT_W'(BOOT_IGNORE_CYCLES);
        end else begin
            if (ignore_cnt != '0) begin
                // OS writes NvRAM while booting, those are not worth a backup
                ignore_cnt <= ignore_cnt - 1'b1;
            end else if (nvram_cpu_changed && image_mounted) begin
                backup_pending <= 1'b1;
            end

            // Cleared when the backup starts so a later change can queue another
            if (backup_start) begin
                backup_pending <= 1'b0;
            end
        end
    end

endmodule

/* nvram/nvram_transfer_fsm.sv */
`timescale 1ns/1ps

module nvram_transfer_fsm (
    input  logic                      clk_sys,
    input  logic                      cditop_reset,
    input  logic                      img_mount,
    input  logic                      backup_pending,
    input  logic                      osd_status,
    input  logic                      nvram_hps_ack,
    input  cdi_host_pkg::sd_buff_t    sd_buff,
    input  cdi_host_pkg::byte_t       nvram_backup_data,
    output logic                      nvram_hps_rd,
    output logic                      nvram_hps_wr,
    output cdi_host_pkg::word16_t     nvram_hps_din,
    output cdi_host_pkg::mem13_addr_t nvram_backup_restore_adr,
    output cdi_host_pkg::byte_t       nvram_restore_data,
    output logic                      nvram_restore_write,
    output logic                      nvram_allow_cpu_access,
    output logic                      backup_start
);
    import cdi_host_pkg::*;

    nvram_state_e state;
    word16_t      restore_word;
    logic         osd_q;
    logic         buff_addr0_q;

    // CPU owns the NvRAM whenever no transfer runs
    assign nvram_allow_cpu_access = (state == NVRAM_IDLE);

    // Backup on OSD open, a fresh mount has priority
    assign backup_start = (state == NVRAM_IDLE) && !img_mount && backup_pending
                          && osd_status && !osd_q;

    // Even address takes the low byte
    assign nvram_restore_data = nvram_backup_restore_adr[0] ? restore_word[15:8]
                                                            : restore_word[7:0];

    always_ff @(posedge clk_sys) begin
        osd_q        <= osd_status;
        buff_addr0_q <= sd_buff.addr[0];

        if (cditop_reset) begin
            state                    <= NVRAM_IDLE;
            nvram_hps_rd             <= 1'b0;
            nvram_hps_wr             <= 1'b0;
            nvram_restore_write      <= 1'b0;
            nvram_backup_restore_adr <= '0;
        end else begin
            nvram_restore_write <= 1'b0;

            if (nvram_hps_ack) begin
                nvram_hps_rd <= 1'b0;
                nvram_hps_wr <= 1'b0;
            end

            case (state)
                NVRAM_IDLE: begin
                    nvram_backup_restore_adr <= '0;
                    if (img_mount) begin
                        nvram_hps_rd <= 1'b1;
                        state        <= NVRAM_WAIT_FOR_ACK;
                    end else if (backup_start) begin
                        nvram_hps_wr <= 1'b1;
                        state        <= NVRAM_WAIT_FOR_ACK;
                    end
                end
                NVRAM_WAIT_FOR_ACK: begin
                    if (nvram_hps_ack) begin
                        if (nvram_hps_rd) state <= NVRAM_RESTORE0;
                        if (nvram_hps_wr) state <= NVRAM_BACKUP0;
                    end
                end

                // ==========================================================
                // Backup, NvRAM read data lags the address by one cycle
                // ==========================================================
                NVRAM_BACKUP0: begin
                    nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                    state                    <= NVRAM_BACKUP1;
                end
                NVRAM_BACKUP1: begin
                    nvram_hps_din[7:0]       <= nvram_backup_data;
                    nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                    state                    <= NVRAM_BACKUP2;
                end
                NVRAM_BACKUP2: begin
                    nvram_hps_din[15:8] <= nvram_backup_data;
                    state               <= NVRAM_BACKUP3;
                end
                NVRAM_BACKUP3: begin
                    // Host took the word, fetch the next one
                    if (buff_addr0_q != sd_buff.addr[0]) begin
                        nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                        state                    <= NVRAM_BACKUP1;
                    end
                    if (!nvram_hps_ack) begin
                        state <= NVRAM_IDLE;
                    end
                end

                // ==========================================================
                // Restore, one buffer word becomes two byte writes
                // ==========================================================
                NVRAM_RESTORE0: begin
                    if (sd_buff.wr) begin
                        restore_word        <= sd_buff.dout;
                        nvram_restore_write <= 1'b1;
                        state               <= NVRAM_RESTORE1;
                    end
                    if (!nvram_hps_ack) begin
                        state <= NVRAM_IDLE;
                    end
                end
                NVRAM_RESTORE1: begin
                    nvram_restore_write      <= 1'b1;
                    nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                    state                    <= NVRAM_RESTORE2;
                end
                NVRAM_RESTORE2: begin
                    nvram_backup_restore_adr <= nvram_backup_restore_adr + 1'b1;
                    state                    <= NVRAM_RESTORE0;
                end
                default: begin
                    state <= NVRAM_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/cdi_host_bridge.sv */
`timescale 1ns/1ps

module cdi_host_bridge #(
    // 4 s at 30 MHz
    parameter int BOOT_IGNORE_CYCLES = 120_000_000
) (
    input  logic                      clk_sys,
    input  logic                      cditop_reset,

    // Host loader and SDRAM
    input  cdi_host_pkg::host_dl_t    dl,
    input  cdi_host_pkg::sdram_req_t  core_req,
    input  logic                      sdram_busy,
    output cdi_host_pkg::sdram_req_t  mem_req,
    output logic                      dl_overflow,
    output cdi_host_pkg::worm_wr_t    worm,

    // SD card image side
    input  cdi_host_pkg::sd_buff_t    sd_buff,
    input  logic                      nvram_hps_ack,
    input  logic [63:0]               img_size,
    input  logic                      nvram_media_change,
    input  logic                      osd_status,
    output logic                      nvram_hps_rd,
    output logic                      nvram_hps_wr,
    output cdi_host_pkg::word16_t     nvram_hps_din,

    // NvRAM byte port of the console
    input  logic                      nvram_cpu_changed,
    input  cdi_host_pkg::byte_t       nvram_backup_data,
    output cdi_host_pkg::mem13_addr_t nvram_backup_restore_adr,
    output cdi_host_pkg::byte_t       nvram_restore_data,
    output logic                      nvram_restore_write,
    output logic                      nvram_allow_cpu_access,
    output logic                      led_user
);

    logic img_mount;
    logic backup_pending;
    logic backup_start;

    sdram_prep_arbiter u_sdram_prep_arbiter (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .dl           (dl),
        .core_req     (core_req),
        .sdram_busy   (sdram_busy),
        .mem_req      (mem_req),
        .dl_overflow  (dl_overflow)
    );

    worm_loader u_worm_loader (
        .clk_sys (clk_sys),
        .dl      (dl),
        .worm    (worm)
    );

    nvram_backup_policy #(
        .BOOT_IGNORE_CYCLES (BOOT_IGNORE_CYCLES)
    ) u_nvram_backup_policy (
        .clk_sys            (clk_sys),
        .cditop_reset       (cditop_reset),
        .nvram_media_change (nvram_media_change),
        .img_size           (img_size),
        .nvram_cpu_changed  (nvram_cpu_changed),
        .backup_start       (backup_start),
        .img_mount          (img_mount),
        .backup_pending     (backup_pending)
    );

    nvram_transfer_fsm u_nvram_transfer_fsm (
        .clk_sys                  (clk_sys),
        .cditop_reset             (cditop_reset),
        .img_mount                (img_mount),
        .backup_pending           (backup_pending),
        .osd_status               (osd_status),
        .nvram_hps_ack            (nvram_hps_ack),
        .sd_buff                  (sd_buff),
        .nvram_backup_data        (nvram_backup_data),
        .nvram_hps_rd             (nvram_hps_rd),
        .nvram_hps_wr             (nvram_hps_wr),
        .nvram_hps_din            (nvram_hps_din),
        .nvram_backup_restore_adr (nvram_backup_restore_adr),
        .nvram_restore_data       (nvram_restore_data),
        .nvram_restore_write      (nvram_restore_write),
        .nvram_allow_cpu_access   (nvram_allow_cpu_access),
        .backup_start             (backup_start)
    );

    // LED lit while a backup is still owed
    assign led_user = backup_pending;

endmodule

/* tests/tb_cdi_host_bridge.sv */
`timescale 1ns/1ps

module tb_cdi_host_bridge;
    import cdi_host_pkg::*;

    localparam int BOOT_IGNORE = 20;
    localparam int N_CORE      = 4;
    localparam int N_ROM       = 4;
    localparam int N_WORM      = 4;
    localparam int N_RESTORE   = 4;
    localparam int N_BACKUP    = 6;
    localparam int WATCHDOG_CYCLES = 200 + 3 * BOOT_IGNORE + N_CORE * 2 + N_ROM * 30
                                     + N_WORM * 5 + N_RESTORE * 6 + N_BACKUP * 8;

    typedef struct packed {
        host_addr_t  addr;
        word16_t     data;
        sdram_addr_t exp_addr;
        word16_t     exp_din;
    } rom_entry_t;

    typedef struct packed {
        host_addr_t  addr;
        word16_t     data;
        mem13_addr_t exp_adr_lo;
        mem13_addr_t exp_adr_hi;
    } worm_entry_t;

    logic        clk_sys;
    logic        cditop_reset;
    host_dl_t    dl;
    sdram_req_t  core_req;
    logic        sdram_busy = 1'b0;
    sdram_req_t  mem_req;
    logic        dl_overflow;
    worm_wr_t    worm;
    sd_buff_t    sd_buff;
    logic        nvram_hps_ack;
    logic [63:0] img_size;
    logic        nvram_media_change;
    logic        osd_status;
    logic        nvram_hps_rd;
    logic        nvram_hps_wr;
    word16_t     nvram_hps_din;
    logic        nvram_cpu_changed;
    byte_t       nvram_backup_data = 8'h00;
    mem13_addr_t nvram_backup_restore_adr;
    byte_t       nvram_restore_data;
    logic        nvram_restore_write;
    logic        nvram_allow_cpu_access;
    logic        led_user;

    integer      seed = 66980;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_errors = 0;
    int          busy_left = 0;
    logic        rom_phase = 1'b0;
    logic [41:0] rom_seen [$];
    logic [20:0] restore_seen [$];
    byte_t       nv_mem [0:8191];

    sdram_req_t  core_tab [N_CORE];
    rom_entry_t  rom_tab [N_ROM];
    worm_entry_t worm_tab [N_WORM];
    word16_t     restore_tab [N_RESTORE];

    cdi_host_bridge #(
        .BOOT_IGNORE_CYCLES (BOOT_IGNORE)
    ) u_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    // ======================================================================
    // Bus models and monitors
    // ======================================================================

    // SDRAM stays busy for 3 cycles after each access
    always @(posedge clk_sys) begin
        if (busy_left > 1) begin
            busy_left <= busy_left - 1;
        end else if (busy_left == 1) begin
            busy_left  <= 0;
            sdram_busy <= 1'b0;
        end else if (mem_req.rd || mem_req.wr) begin
            busy_left  <= 3;
            sdram_busy <= 1'b1;
        end
    end

    // NvRAM with registered read
    always @(posedge clk_sys) begin
        nvram_backup_data <= nv_mem[nvram_backup_restore_adr];
        if (nvram_restore_write) begin
            nv_mem[nvram_backup_restore_adr] <= nvram_restore_data;
        end
    end

    always @(negedge clk_sys) begin
        if (rom_phase && mem_req.wr) begin
            rom_seen.push_back({mem_req.addr, mem_req.din, mem_req.word});
        end
        if (nvram_restore_write) begin
            restore_seen.push_back({nvram_backup_restore_adr, nvram_restore_data});
        end
        // Every read issued during reset is a refresh
        if (cditop_reset && mem_req.rd) begin
            check_value("mem_req.refresh", mem_req.refresh, 1);
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Check failed at t=%0t: %s", $time, what);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-18s %s (%0d errors)", name,
                 (errors == test_errors) ? "ok" : "failed", errors - test_errors);
        test_errors = errors;
    endtask

    task automatic build_tables();
        logic [63:0] r;
        for (int i = 0; i < N_CORE; i++) begin
            r = {$random(seed), $random(seed)};
            core_tab[i] = r[45:0];
        end
        for (int i = 0; i < N_ROM; i++) begin
            r = {$random(seed), $random(seed)};
            rom_tab[i].addr     = r[24:0];
            rom_tab[i].data     = r[40:25];
            // ROM region prefix 001, word address, bytes swapped
            rom_tab[i].exp_addr = {3'b001, rom_tab[i].addr[21:1], 1'b0};
            rom_tab[i].exp_din  = {rom_tab[i].data[7:0], rom_tab[i].data[15:8]};
        end
        for (int i = 0; i < N_WORM; i++) begin
            r = {$random(seed), $random(seed)};
            worm_tab[i].addr       = r[24:0];
            worm_tab[i].data       = r[40:25];
            worm_tab[i].exp_adr_lo = worm_tab[i].addr[12:0];
            worm_tab[i].exp_adr_hi = {worm_tab[i].addr[12:1], 1'b1};
        end
        for (int i = 0; i < N_RESTORE; i++) begin
            r = {$random(seed), $random(seed)};
            restore_tab[i] = r[15:0];
        end
        for (int i = 0; i < 8192; i++) begin
            r = {$random(seed), $random(seed)};
            nv_mem[i] = r[7:0];
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        int n;
        int refresh_count;
        cditop_reset       = 1'b1;
        dl                 = '0;
        core_req           = '0;
        sd_buff            = '0;
        nvram_hps_ack      = 1'b0;
        img_size           = 64'd0;
        nvram_media_change = 1'b0;
        osd_status         = 1'b0;
        nvram_cpu_changed  = 1'b0;
        build_tables();
        repeat (5) @(posedge clk_sys);
        cditop_reset <= 1'b0;

        for (int i = 0; i < N_CORE; i++) begin
            @(posedge clk_sys);
            core_req <= core_tab[i];
            @(negedge clk_sys);
            check_value("mem_req", mem_req, core_tab[i]);
        end
        @(posedge clk_sys);
        core_req <= '0;
        end_test("core_passthrough");

        // Mount an image, host then streams the NvRAM contents
        @(posedge clk_sys);
        img_size           <= 64'd8192;
        nvram_media_change <= 1'b1;
        @(posedge clk_sys);
        nvram_media_change <= 1'b0;
        n = 0;
        while (!nvram_hps_rd && n < 10) begin
            @(negedge clk_sys);
            n++;
        end
        check_true(nvram_hps_rd, "no NvRAM read request after image mount");
        @(posedge clk_sys);
        nvram_hps_ack <= 1'b1;
        for (int i = 0; i < N_RESTORE; i++) begin
            @(posedge clk_sys);
            sd_buff.wr   <= 1'b1;
            sd_buff.dout <= restore_tab[i];
            @(posedge clk_sys);
            sd_buff.wr <= 1'b0;
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("nvram_allow_cpu_access", nvram_allow_cpu_access, 0);
        end
        @(posedge clk_sys);
        nvram_hps_ack <= 1'b0;
        n = 0;
        while (!nvram_allow_cpu_access && n < 10) begin
            @(negedge clk_sys);
            n++;
        end
        check_true(nvram_allow_cpu_access, "CPU access not returned after restore");
        check_value("restore_write_count", restore_seen.size(), 2 * N_RESTORE);
        for (int j = 0; j < restore_seen.size() && j < 2 * N_RESTORE; j++) begin
            check_value("nvram_backup_restore_adr", restore_seen[j][20:8], j);
            check_value("nvram_restore_data", restore_seen[j][7:0],
                        (j % 2) ? restore_tab[j / 2][15:8] : restore_tab[j / 2][7:0]);
        end
        end_test("nvram_restore");

        // Console held in reset for the ROM download
        @(posedge clk_sys);
        cditop_reset   <= 1'b1;
        rom_phase      <= 1'b1;
        dl.download    <= 1'b1;
        refresh_count = 0;
        repeat (16) begin
            @(negedge clk_sys);
            if (mem_req.rd && mem_req.refresh) begin
                refresh_count++;
            end
        end
        check_true(refresh_count > 0, "no refresh request while idle in reset");
        check_value("rom_write_count", rom_seen.size(), 0);
        end_test("refresh_idle");

        for (int i = 0; i < N_ROM; i++) begin
            @(posedge clk_sys);
            dl.wr    <= 1'b1;
            dl.addr  <= rom_tab[i].addr;
            dl.dout  <= rom_tab[i].data;
            dl.index <= 16'h0000;
            @(posedge clk_sys);
            dl.wr <= 1'b0;
            n = 0;
            while (rom_seen.size() <= i && n < 20) begin
                @(negedge clk_sys);
                n++;
            end
            check_true(rom_seen.size() > i, "ROM word never written to SDRAM");
            @(negedge clk_sys);
            n = 0;
            while (sdram_busy && n < 10) begin
                @(negedge clk_sys);
                n++;
            end
            @(posedge clk_sys);
        end
        check_value("rom_write_count", rom_seen.size(), N_ROM);
        for (int i = 0; i < N_ROM && i < rom_seen.size(); i++) begin
            check_value("mem_req.addr", rom_seen[i][41:17], rom_tab[i].exp_addr);
            check_value("mem_req.din", rom_seen[i][16:1], rom_tab[i].exp_din);
            check_value("mem_req.word", rom_seen[i][0], 1);
        end
        check_value("dl_overflow", dl_overflow, 0);
        end_test("rom_download");

        // Index bit 6 selects the slave WORM
        for (int i = 0; i < N_WORM; i++) begin
            @(posedge clk_sys);
            dl.wr    <= 1'b1;
            dl.addr  <= worm_tab[i].addr;
            dl.dout  <= worm_tab[i].data;
            dl.index <= 16'h0040;
            @(posedge clk_sys);
            dl.wr <= 1'b0;
            @(negedge clk_sys);
            check_value("worm.wr", worm.wr, 1);
            check_value("worm.adr", worm.adr, worm_tab[i].exp_adr_lo);
            check_value("worm.data", worm.data, worm_tab[i].data[7:0]);
            @(negedge clk_sys);
            check_value("worm.wr", worm.wr, 1);
            check_value("worm.adr", worm.adr, worm_tab[i].exp_adr_hi);
            check_value("worm.data", worm.data, worm_tab[i].data[15:8]);
            @(negedge clk_sys);
            check_value("worm.wr", worm.wr, 0);
        end
        check_value("rom_write_count", rom_seen.size(), N_ROM);
        end_test("worm_load");

        // Two host words back to back, the second finds the latch still set
        @(posedge clk_sys);
        rom_phase <= 1'b0;
        dl.wr     <= 1'b1;
        dl.index  <= 16'h0000;
        @(posedge clk_sys);
        dl.dout <= ~dl.dout;
        @(posedge clk_sys);
        dl.wr <= 1'b0;
        @(negedge clk_sys);
        check_value("dl_overflow", dl_overflow, 1);
        repeat (12) @(negedge clk_sys);
        check_value("dl_overflow", dl_overflow, 1);
        end_test("dl_overflow");

        @(posedge clk_sys);
        cditop_reset <= 1'b0;
        dl.download  <= 1'b0;
        repeat (3) @(posedge clk_sys);
        nvram_cpu_changed <= 1'b1;
        @(posedge clk_sys);
        nvram_cpu_changed <= 1'b0;
        repeat (4) @(negedge clk_sys);
        check_value("led_user", led_user, 0);
        repeat (BOOT_IGNORE + 5) @(posedge clk_sys);
        nvram_cpu_changed <= 1'b1;
        @(posedge clk_sys);
        nvram_cpu_changed <= 1'b0;
        n = 0;
        while (!led_user && n < 10) begin
            @(negedge clk_sys);
            n++;
        end
        check_true(led_user, "CPU change after the boot window left the LED off");
        end_test("led_pending");

        // Opening the OSD starts the backup
        @(posedge clk_sys);
        osd_status <= 1'b1;
        n = 0;
        while (!nvram_hps_wr && n < 10) begin
            @(negedge clk_sys);
            n++;
        end
        check_true(nvram_hps_wr, "no NvRAM write request after OSD opened");
        check_value("led_user", led_user, 0);
        @(posedge clk_sys);
        nvram_hps_ack <= 1'b1;
        repeat (6) @(posedge clk_sys);
        check_value("nvram_hps_wr", nvram_hps_wr, 0);
        for (int j = 0; j < N_BACKUP; j++) begin
            @(negedge clk_sys);
            check_value("nvram_hps_din", nvram_hps_din, {nv_mem[2 * j + 1], nv_mem[2 * j]});
            if (j < N_BACKUP - 1) begin
                @(posedge clk_sys);
                sd_buff.addr <= sd_buff.addr + 8'd1;
                repeat (5) @(posedge clk_sys);
            end
        end
        @(posedge clk_sys);
        nvram_hps_ack <= 1'b0;
        osd_status    <= 1'b0;
        n = 0;
        while (!nvram_allow_cpu_access && n < 10) begin
            @(negedge clk_sys);
            n++;
        end
        check_true(nvram_allow_cpu_access, "CPU access not returned after backup");
        end_test("nvram_backup");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* sources.f */
common/cdi_host_pkg.sv
sdram_prep/sdram_prep_arbiter.sv
logic/worm_loader.sv
nvram/nvram_backup_policy.sv
nvram/nvram_transfer_fsm.sv
logic/cdi_host_bridge.sv
tests/tb_cdi_host_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

rm -f build/sim.log
mkdir -p build &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cdi_host_bridge -Mdir build/obj_dir -o sim_tb -f sources.f &&
./build/obj_dir/sim_tb > build/sim.log 2>&1 ||
{ cat build/sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat build/sim.log
grep -q "=== FAIL ===" build/sim.log && exit 1 || exit 0
